//--- rtl/scr_pkg.sv
package scr_pkg;

    // rom ports, word addresses
    localparam int MAP_AW  = 14;  // page + 5 row bits + 6 column bits
    localparam int TILE_AW = 17;  // code + tile row + half select

    // field widths
    localparam int POS_W  = 9;           // scan counters span 512
    localparam int PAL_W  = 7;
    localparam int COL_W  = 3;           // one bit per plane
    localparam int CODE_W = 13;          // bank bit on top of tile number
    localparam int ATTR_W = 1 + PAL_W;   // priority then palette
    localparam int SUB_W  = 3;           // pixel index inside a tile

    // one line buffer entry
    typedef struct packed {
        logic             prio;
        logic [PAL_W-1:0] palette;
        logic [COL_W-1:0] colour;   // msb from plane 2
    } scr_pxl_t;

    // map word decoded for the tile stage
    typedef struct packed {
        logic [CODE_W-1:0] code;
        logic [ATTR_W-1:0] attr;
        logic [SUB_W-1:0]  row;   // from vpos low bits
        logic [SUB_W-1:0]  col;   // first column drawn
    } tile_req_t;

    // render position owned by the tile stage
    typedef struct packed {
        logic [POS_W-1:0] hscan;
        logic [POS_W-1:0] vscan;
        logic             done;   // line finished, fetch idles
    } scan_pos_t;

endpackage

//--- rtl/scr_map_fetch.sv
`timescale 1ns/1ns

module scr_map_fetch #(
    parameter int pxl_dly = 0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  scr_pkg::scan_pos_t          scan,
    input  logic [15:0]                 hscr,
    input  logic [15:0]                 vscr,
    input  logic [15:0]                 pages,
    input  logic                        map_ok,
    input  logic [15:0]                 map_data,
    input  logic                        busy,
    output logic [scr_pkg::MAP_AW-1:0]  map_addr,
    output logic                        draw,
    output scr_pkg::tile_req_t          req
);

    logic [1:0] st;         // 0 addr, 1-2 wait, 3 hold for data
    logic       in_flight;  // a tile is between draw and busy drop
    logic [2:0] col_now;    // offset column at the live hscan
    logic [3:0] step;
    logic [8:0] hscan_la;   // start of the tile to fetch next
    logic [8:0] hpos;
    logic [7:0] vpos;
    logic       hov;
    logic       vov;
    logic [2:0] page;
    logic       go;

    assign in_flight = busy | draw;

    // while a tile is shifting, hscan sits on its first pixel
    // so jump ahead to the next tile boundary
    assign col_now  = scan.hscan[2:0] + ~hscr[2:0] + 3'(pxl_dly);
    assign step     = 4'd8 - {1'b0, col_now};
    assign hscan_la = in_flight ? scan.hscan + {5'd0, step} : scan.hscan;

    always_comb begin
        {hov, hpos} = {1'b0, hscan_la} + {1'b0, ~hscr[8:0]} + 10'(pxl_dly);
        {vov, vpos} = {1'b0, scan.vscan[7:0]} + {1'b0, vscr[7:0]};
        case ({vov, hov})  // overflow picks the page field
            2'b01:   page = pages[2:0];
            2'b00:   page = pages[6:4];
            2'b11:   page = pages[10:8];
            default: page = pages[14:12];
        endcase
    end

    assign go = (st == 2'd3) && map_ok && !busy;  // data in, tile stage free

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= 2'd0;
            map_addr <= '0;
            draw     <= 1'b0;
        end else if (scan.done) begin
            st   <= 2'd0;  // idle till the next blank start
            draw <= 1'b0;
        end else begin
            draw <= 1'b0;
            case (st)
                2'd0: begin
                    map_addr <= {page, vpos[7:3], hpos[8:3]};
                    st       <= 2'd1;
                end
                2'd1: st <= 2'd2;  // give the rom time to drop ok
                2'd2: st <= 2'd3;
                default: begin
                    if (go) begin
                        draw <= 1'b1;
                        st   <= 2'd0;  // next read overlaps the shift
                    end
                end
            endcase
        end
    end

    // request fields latched with the draw pulse
    always_ff @(posedge clk) begin
        if (go && !scan.done) begin
            req.code <= {map_data[13], map_data[11:0]};
            req.attr <= map_data[12:5];
            req.row  <= vpos[2:0];
            req.col  <= hpos[2:0];
        end
    end

    // look-ahead counts on busy taking over straight from draw
    busy_after_draw : assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(draw));

endmodule

//--- rtl/scr_tile_shift.sv
`timescale 1ns/1ns

module scr_tile_shift #(
    parameter logic [8:0] hb_end = 9'h70
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl2_cen,
    input  logic                         lhbl,
    input  logic [8:0]                   vrender,
    input  logic                         draw,
    input  scr_pkg::tile_req_t           req,
    input  logic                         tile_ok,
    input  logic [31:0]                  tile_data,
    output logic [scr_pkg::TILE_AW-1:0]  tile_addr,
    output logic                         busy,
    output scr_pkg::scan_pos_t           scan,
    output logic                         we,
    output logic [8:0]                   wr_addr,
    output scr_pkg::scr_pxl_t            wr_pxl
);

    logic                        lhbl_q;
    logic                        blank_start;
    logic                        ok_q;       // tile_ok one cycle back
    logic                        loaded;     // planes hold the current tile
    logic                        capture;
    logic                        shift;
    logic [2:0]                  col;        // offset column of next pixel
    logic [scr_pkg::ATTR_W-1:0]  attr;
    logic [2:0][7:0]             planes;     // msb is the next pixel

    assign blank_start = lhbl_q & ~lhbl;
    // ok must stay up two cycles so a stale level from the last tile is ignored
    assign capture = busy && !loaded && ok_q && tile_ok;
    assign shift   = busy && loaded && pxl2_cen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_q    <= 1'b0;
            scan      <= '0;
            busy      <= 1'b0;
            loaded    <= 1'b0;
            ok_q      <= 1'b0;
            we        <= 1'b0;
            tile_addr <= '0;
        end else begin
            lhbl_q <= lhbl;
            ok_q   <= tile_ok;
            we     <= shift;  // buffer write one clock after the shift
            if (draw) begin
                tile_addr <= {req.code, req.row, 1'b0};
                busy      <= 1'b1;
                loaded    <= 1'b0;
                ok_q      <= 1'b0;  // restart the settle count
            end else if (capture) begin
                loaded <= 1'b1;
            end
            if (shift) begin
                scan.hscan <= scan.hscan + 9'd1;
                if (col == 3'd7 || &scan.hscan)
                    busy <= 1'b0;  // tile edge or end of line
                if (&scan.hscan)
                    scan.done <= 1'b1;
            end
            if (blank_start) begin
                scan <= '{hscan: hb_end - 9'd8, vscan: vrender, done: 1'b0};
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (draw) begin
            attr <= req.attr;
            col  <= req.col;
        end
        if (capture) begin
            // low three bytes are the planes, skip columns already left of hscan
            for (int i = 0; i < 3; i++)
                planes[i] <= tile_data[8*i +: 8] << col;
        end
        if (shift) begin
            for (int i = 0; i < 3; i++)
                planes[i] <= planes[i] << 1;
            col            <= col + 3'd1;
            wr_addr        <= scan.hscan;
            wr_pxl.prio    <= attr[7];
            wr_pxl.palette <= attr[6:0];
            wr_pxl.colour  <= {planes[2][7], planes[1][7], planes[0][7]};
        end
    end

    // fetch side must wait for the previous tile to drain
    no_draw_when_busy : assert property (@(posedge clk) disable iff (rst)
        draw |-> !busy);

endmodule

//--- rtl/scr_linebuf.sv
`timescale 1ns/1ns

module scr_linebuf (
    input  logic               clk,
    input  logic               rst,
    input  logic               lhbl,
    input  logic               we,
    input  logic [8:0]         wr_addr,
    input  scr_pkg::scr_pxl_t  wr_pxl,
    input  logic [8:0]         rd_addr,
    output scr_pkg::scr_pxl_t  pxl
);

    scr_pkg::scr_pxl_t mem [2][512];  // one bank rendered, one shown
    scr_pkg::scr_pxl_t rd_data;
    logic              lhbl_q;
    logic              swap;
    logic              wr_bank;
    logic              primed;   // a rendered bank is on display
    logic              erase;
    logic [8:0]        last_rd;

    assign swap    = lhbl_q & ~lhbl;
    assign erase   = rd_addr != last_rd;  // hdump moved on, wipe what was shown
    assign rd_data = mem[!wr_bank][rd_addr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lhbl_q  <= 1'b0;
            wr_bank <= 1'b0;
            primed  <= 1'b0;
            last_rd <= '0;
            pxl     <= '0;
        end else begin
            lhbl_q  <= lhbl;
            last_rd <= rd_addr;
            if (swap) begin
                wr_bank <= ~wr_bank;
                primed  <= 1'b1;
            end
            pxl <= (lhbl && primed) ? rd_data : '0;  // black in blank
        end
    end

    // each bank takes either render writes or erase writes
    for (genvar b = 0; b < 2; b++) begin : g_bank
        always_ff @(posedge clk) begin
            if (wr_bank == 1'(b)) begin
                if (we)
                    mem[b][wr_addr] <= wr_pxl;
            end else if (erase) begin
                mem[b][last_rd] <= '0;
            end
        end
    end

    // render must be finished when the halves trade places
    no_write_on_swap : assert property (@(posedge clk) disable iff (rst)
        swap |-> !we);

endmodule

//--- rtl/scr_layer.sv
`timescale 1ns/1ns

module scr_layer #(
    parameter logic [8:0] hb_end  = 9'h70,
    parameter int         pxl_dly = 0
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl2_cen,
    input  logic                         lhbl,
    input  logic [15:0]                  pages,
    input  logic [15:0]                  hscr,
    input  logic [15:0]                  vscr,
    input  logic                         map_ok,
    input  logic [15:0]                  map_data,
    input  logic                         tile_ok,
    input  logic [31:0]                  tile_data,
    input  logic [8:0]                   vrender,
    input  logic [8:0]                   hdump,
    output logic [scr_pkg::MAP_AW-1:0]   map_addr,
    output logic [scr_pkg::TILE_AW-1:0]  tile_addr,
    output scr_pkg::scr_pxl_t            pxl
);

    scr_pkg::scan_pos_t scan;     // tile stage to fetch
    scr_pkg::tile_req_t req;      // fetch to tile stage
    scr_pkg::scr_pxl_t  wr_pxl;
    logic               draw;
    logic               busy;
    logic               we;
    logic [8:0]         wr_addr;

    scr_map_fetch #(
        .pxl_dly (pxl_dly)
    ) u_map_fetch (
        .clk      (clk),
        .rst      (rst),
        .scan     (scan),
        .hscr     (hscr),
        .vscr     (vscr),
        .pages    (pages),
        .map_ok   (map_ok),
        .map_data (map_data),
        .busy     (busy),
        .map_addr (map_addr),
        .draw     (draw),
        .req      (req)
    );

    scr_tile_shift #(
        .hb_end (hb_end)
    ) u_tile_shift (
        .clk       (clk),
        .rst       (rst),
        .pxl2_cen  (pxl2_cen),
        .lhbl      (lhbl),
        .vrender   (vrender),
        .draw      (draw),
        .req       (req),
        .tile_ok   (tile_ok),
        .tile_data (tile_data),
        .tile_addr (tile_addr),
        .busy      (busy),
        .scan      (scan),
        .we        (we),
        .wr_addr   (wr_addr),
        .wr_pxl    (wr_pxl)
    );

    // readout at hdump, one clock behind
    scr_linebuf u_linebuf (
        .clk     (clk),
        .rst     (rst),
        .lhbl    (lhbl),
        .we      (we),
        .wr_addr (wr_addr),
        .wr_pxl  (wr_pxl),
        .rd_addr (hdump),
        .pxl     (pxl)
    );

endmodule

//--- verification/scr_rom_model.sv
`timescale 1ns/1ns

module scr_rom_model (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rand_dly,   // 1 to 6 clock ok delay when set
    input  logic [scr_pkg::MAP_AW-1:0]   map_addr,
    output logic                         map_ok,
    output logic [15:0]                  map_data,
    input  logic [scr_pkg::TILE_AW-1:0]  tile_addr,
    output logic                         tile_ok,
    output logic [31:0]                  tile_data
);

    integer                      seed = 3028;
    logic [scr_pkg::MAP_AW-1:0]  map_last;
    logic [scr_pkg::TILE_AW-1:0] tile_last;
    logic [2:0]                  map_cnt;    // clocks left until ok
    logic [2:0]                  tile_cnt;

    function automatic logic [2:0] next_delay();
        int d;
        d = 1;
        if (rand_dly)
            d = 1 + ($unsigned($random(seed)) % 6);
        return 3'(d);
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            map_last  <= '0;
            tile_last <= '0;
            map_cnt   <= 3'd1;  // address zero answers after reset
            tile_cnt  <= 3'd1;
            map_ok    <= 1'b0;
            tile_ok   <= 1'b0;
            map_data  <= '0;
            tile_data <= '0;
        end else begin
            if (map_addr != map_last) begin
                map_last <= map_addr;
                map_ok   <= 1'b0;   // new address, data no longer valid
                map_cnt  <= next_delay();
            end else if (map_cnt != 3'd0) begin
                map_cnt <= map_cnt - 3'd1;
                if (map_cnt == 3'd1) begin
                    map_ok   <= 1'b1;
                    map_data <= 16'(map_last * 37 + 5);
                end
            end
            if (tile_addr != tile_last) begin
                tile_last <= tile_addr;
                tile_ok   <= 1'b0;
                tile_cnt  <= next_delay();
            end else if (tile_cnt != 3'd0) begin
                tile_cnt <= tile_cnt - 3'd1;
                if (tile_cnt == 3'd1) begin
                    tile_ok   <= 1'b1;
                    tile_data <= 32'(tile_last * 32'h9E3779B1);  // multiplicative hash
                end
            end
        end
    end

endmodule

//--- verification/scr_layer_tb.sv
`timescale 1ns/1ns

module scr_layer_tb;

    localparam logic [8:0] hb_end    = 9'h70;
    localparam int         pxl_dly   = 0;
    localparam int         line_clks = 512 * 8;
    localparam int         n_rows    = 9;

    typedef struct packed {
        logic [15:0]     hscr;
        logic [15:0]     vscr;
        logic [15:0]     pages;
        logic            bp;    // random rom delays
        logic [7:0][8:0] pos;   // hdump samples with pos[7] taken first
    } row_t;

    logic                         clk      = 1'b0;
    logic                         rst      = 1'b1;
    logic                         pxl2_cen = 1'b0;
    logic [15:0]                  pages    = '0;
    logic [15:0]                  hscr     = '0;
    logic [15:0]                  vscr     = '0;
    logic [8:0]                   vrender  = '0;
    logic [8:0]                   hdump    = '0;
    logic                         rand_dly = 1'b0;
    logic [2:0]                   sub      = '0;  // clock within one hdump step
    logic                         lhbl;
    logic                         map_ok;
    logic                         tile_ok;
    logic [15:0]                  map_data;
    logic [31:0]                  tile_data;
    logic [scr_pkg::MAP_AW-1:0]   map_addr;
    logic [scr_pkg::TILE_AW-1:0]  tile_addr;
    scr_pkg::scr_pxl_t            pxl;
    scr_pkg::scr_pxl_t            exp_pxl;
    row_t                         rows [n_rows];
    string                        names [n_rows];

    assign lhbl = hdump >= hb_end;

    scr_layer #(
        .hb_end  (hb_end),
        .pxl_dly (pxl_dly)
    ) scr_layer_i (
        .clk       (clk),
        .rst       (rst),
        .pxl2_cen  (pxl2_cen),
        .lhbl      (lhbl),
        .pages     (pages),
        .hscr      (hscr),
        .vscr      (vscr),
        .map_ok    (map_ok),
        .map_data  (map_data),
        .tile_ok   (tile_ok),
        .tile_data (tile_data),
        .vrender   (vrender),
        .hdump     (hdump),
        .map_addr  (map_addr),
        .tile_addr (tile_addr),
        .pxl       (pxl)
    );

    scr_rom_model rom (
        .clk       (clk),
        .rst       (rst),
        .rand_dly  (rand_dly),
        .map_addr  (map_addr),
        .map_ok    (map_ok),
        .map_data  (map_data),
        .tile_addr (tile_addr),
        .tile_ok   (tile_ok),
        .tile_data (tile_data)
    );

    initial begin
        forever #20 clk = ~clk;
    end

    // video timing driven on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            sub      <= '0;
            hdump    <= '0;
            vrender  <= '0;
            pxl2_cen <= 1'b0;
        end else begin
            sub      <= sub + 3'd1;
            pxl2_cen <= sub[1:0] == 2'd2;  // one clock in four
            if (sub == 3'd7) begin
                hdump <= hdump + 9'd1;
                if (hdump == 9'd511)
                    vrender <= vrender + 9'd1;  // blank start
            end
        end
    end

    function automatic logic [15:0] map_word_of(input logic [scr_pkg::MAP_AW-1:0] a);
        return 16'(a * 37 + 5);
    endfunction

    function automatic logic [31:0] tile_word_of(input logic [scr_pkg::TILE_AW-1:0] a);
        return 32'(a * 32'd2654435761);
    endfunction

    task automatic expected_pxl(input logic [8:0] h, input logic [8:0] vscan,
                                input row_t rw, output scr_pkg::scr_pxl_t px);
        int          hsum;
        int          vsum;
        int          hpos;
        int          vpos;
        int          field;
        logic [2:0]  page;
        logic [15:0] mword;
        logic [31:0] tword;
        int          ci;
        hsum  = int'(h) + (511 - int'(rw.hscr[8:0])) + pxl_dly;  // complement of hscr
        vsum  = int'(vscan[7:0]) + int'(rw.vscr[7:0]);
        hpos  = hsum % 512;
        vpos  = vsum % 256;
        // field index follows the page table rows
        field = 2 * (vsum / 256) + (((hsum / 512) % 2 == 1) ? 0 : 1);
        page  = 3'(rw.pages >> (4 * field));
        mword = map_word_of({page, 5'(vpos / 8), 6'(hpos / 8)});
        tword = tile_word_of({mword[13], mword[11:0], 3'(vpos % 8), 1'b0});
        ci    = 7 - (hpos % 8);  // leftmost pixel is the plane msb
        px.prio    = mword[12];
        px.palette = mword[11:5];
        px.colour  = {tword[16 + ci], tword[8 + ci], tword[ci]};
        if (h < hb_end)
            px = '0;  // blanked
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    // returns on the falling edge where vrender has moved on
    task automatic wait_line_start(input logic check_dark);
        logic [8:0] v0;
        int         n;
        v0 = vrender;
        n  = 0;
        while (vrender == v0) begin
            if (check_dark)
                assert (pxl === '0) else
                    abort_run($sformatf("CHECK FAILED first_line hdump %0d expected %h actual %h",
                                        hdump, 11'h000, pxl));
            if (n > 2 * line_clks)
                abort_run("timed out waiting for a line start");
            n++;
            @(negedge clk);
        end
    endtask

    // returns on the first falling edge that sees hdump at target
    task automatic wait_hdump(input logic [8:0] target);
        int n;
        n = 0;
        while (hdump != target) begin
            if (n > 2 * line_clks)
                abort_run($sformatf("timed out waiting for hdump %0d", target));
            n++;
            @(negedge clk);
        end
    endtask

    initial begin
        logic [8:0] h;
        // hscr vscr pages bp then eight hdump positions
        rows[0] = {16'h0000, 16'h0000, 16'h0000, 1'b0,
                   {9'h008, 9'h06f, 9'h070, 9'h071, 9'h0a5, 9'h100, 9'h1b3, 9'h1ff}};
        rows[1] = {16'h0003, 16'h0000, 16'h4321, 1'b0,
                   {9'h070, 9'h077, 9'h078, 9'h07c, 9'h0c1, 9'h13e, 9'h1a0, 9'h1fe}};
        rows[2] = {16'h0150, 16'h0000, 16'h4321, 1'b0,
                   {9'h070, 9'h0d2, 9'h14f, 9'h150, 9'h151, 9'h152, 9'h1c9, 9'h1ff}};
        rows[3] = {16'h01fa, 16'h0000, 16'h7531, 1'b0,
                   {9'h06a, 9'h070, 9'h0f3, 9'h1a8, 9'h1f9, 9'h1fa, 9'h1fb, 9'h1ff}};
        rows[4] = {16'h0000, 16'h00ff, 16'h4321, 1'b0,
                   {9'h060, 9'h071, 9'h0b0, 9'h0e9, 9'h123, 9'h18d, 9'h1d0, 9'h1fd}};
        rows[5] = {16'h0150, 16'h00f3, 16'h6543, 1'b0,
                   {9'h075, 9'h0c8, 9'h14f, 9'h151, 9'h166, 9'h1a1, 9'h1e7, 9'h1ff}};
        rows[6] = {rows[0][120:73], 1'b1, rows[0][71:0]};  // same rows with slow roms
        rows[7] = {rows[2][120:73], 1'b1, rows[2][71:0]};
        rows[8] = {rows[5][120:73], 1'b1, rows[5][71:0]};
        names = '{"zero_scroll", "hscroll_small", "hscroll_page", "hscroll_wrap",
                  "vscroll_ov", "vh_scroll", "zero_scroll_bp", "hscroll_page_bp",
                  "vh_scroll_bp"};
        repeat (4) @(negedge clk);
        assert (map_addr === '0) else
            abort_run($sformatf("CHECK FAILED reset map_addr expected %h actual %h",
                                14'h0000, map_addr));
        assert (pxl === '0) else
            abort_run($sformatf("CHECK FAILED reset pxl expected %h actual %h",
                                11'h000, pxl));
        rst <= 1'b0;
        @(negedge clk);
        wait_line_start(1'b1);  // nothing shown before the first swap
        for (int r = 0; r < n_rows; r++) begin
            hscr     <= rows[r].hscr;
            vscr     <= rows[r].vscr;
            pages    <= rows[r].pages;
            rand_dly <= rows[r].bp;
            @(negedge clk);
            wait_line_start(1'b0);  // render with the new scroll
            @(negedge clk);
            wait_line_start(1'b0);  // now it is on display
            for (int k = 7; k >= 0; k--) begin
                h = rows[r].pos[k];
                wait_hdump(h);  // one clock after hdump moved to h
                expected_pxl(h, vrender - 9'd1, rows[r], exp_pxl);
                assert (pxl === exp_pxl) else
                    abort_run($sformatf("CHECK FAILED %s hdump %0d expected %h actual %h",
                                        names[r], h, exp_pxl, pxl));
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- list.f
rtl/scr_pkg.sv
rtl/scr_map_fetch.sv
rtl/scr_tile_shift.sv
rtl/scr_linebuf.sv
rtl/scr_layer.sv
verification/scr_rom_model.sv
verification/scr_layer_tb.sv

//--- Bender.yml
package:
  name: scr_layer

sources:
  - rtl/scr_pkg.sv
  - rtl/scr_map_fetch.sv
  - rtl/scr_tile_shift.sv
  - rtl/scr_linebuf.sv
  - rtl/scr_layer.sv
  - target: simulation
    files:
      - verification/scr_rom_model.sv
      - verification/scr_layer_tb.sv
